//--- build.f
cl_grab_pkg.sv
cl_fifo.sv
frame_line_tracker.sv
tap_reassembler.sv
host_ctrl_axil.sv
cl_grab_top.sv
tb_cl_grab.sv

//--- cl_fifo.sv
`timescale 1ns/1ps

module cl_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 16
) (
  input  logic     bus_clk,
  input  logic     reset,
  input  logic     wr,
  input  payload_t din,
  input  logic     rd,
  output payload_t dout,
  output logic     full,
  output logic     empty,
  output logic     ovf
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_wr;
  logic             do_rd;

  // Wrap explicitly so depth need not be a power of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
    if (p == ptr_w'(depth - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign do_wr = wr & ~full;   // Writes to a full FIFO are dropped
  assign do_rd = rd & ~empty;
  assign full  = (count == cnt_w'(depth));
  assign empty = (count == '0);
  assign dout  = mem[rd_ptr];  // Head word falls through

  always_ff @(posedge bus_clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      ovf    <= 1'b0;
    end else begin
      if (do_wr) wr_ptr <= next_ptr(wr_ptr);
      if (do_rd) rd_ptr <= next_ptr(rd_ptr);
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      ovf <= wr & full;  // One-cycle drop flag
    end
  end

  always_ff @(posedge bus_clk) begin
    if (do_wr) mem[wr_ptr] <= din;
  end

  a_no_rd_empty: assert property (@(posedge bus_clk) disable iff (reset) rd |-> !empty);

  // A dropped write leaves the FIFO full unless a word was read meanwhile
  a_ovf_full: assert property (@(posedge bus_clk) disable iff (reset)
    ovf |-> full || $past(rd));

endmodule

//--- cl_grab_pkg.sv
package cl_grab_pkg;

  localparam int frame_num_w = 20;
  localparam int line_num_w  = 12;
  localparam int rec_w       = 128;

  localparam int pad_w  = 12;
  localparam int meta_w = 4;
  localparam int data_w = rec_w - pad_w - meta_w - line_num_w - frame_num_w; // 80 bits

  // x tap carries the frame and line stamp through its FIFO
  typedef struct packed {
    logic [25:0]             data;
    logic                    fval;
    logic                    lval;
    logic [line_num_w-1:0]   line;
    logic [frame_num_w-1:0]  frame;
  } x_tap_t;

  typedef struct packed {
    logic [26:0] data;
    logic        lval;
  } yz_tap_t;

  typedef struct packed {
    logic [data_w-1:0]       data;  // z 79:53, y 52:26, x 25:0
    logic [pad_w-1:0]        pad;
    logic [meta_w-1:0]       meta;  // z_lval, y_lval, x_lval, fval
    logic [line_num_w-1:0]   line;
    logic [frame_num_w-1:0]  frame;
  } rec_t;

  localparam logic [3:0] reg_ctrl   = 4'h0;
  localparam logic [3:0] reg_status = 4'h4;
  localparam logic [3:0] reg_led    = 4'h8;
  localparam logic [3:0] reg_count  = 4'hC;

  localparam int ctrl_arm_bit     = 0;
  localparam int ctrl_cont_bit    = 1;
  localparam int status_ovf_bit   = 0;
  localparam int status_armed_bit = 1;

endpackage

//--- cl_grab_top.sv
`timescale 1ns/1ps

module cl_grab_top #(
  parameter int tap_depth = 16,
  parameter int rec_depth = 8
) (
  input  logic              bus_clk,
  input  logic              reset,
  input  logic              fval,
  input  logic              x_lval,
  input  logic              y_lval,
  input  logic              z_lval,
  input  logic              x_valid,
  input  logic [25:0]       x_data,
  input  logic              y_valid,
  input  logic [26:0]       y_data,
  input  logic              z_valid,
  input  logic [26:0]       z_data,
  input  logic [3:0]        awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [31:0]       wdata,
  input  logic [3:0]        wstrb,
  input  logic              wvalid,
  output logic              wready,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  input  logic [3:0]        araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [31:0]       rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready,
  input  logic              rec_rden,
  output logic              rec_empty,
  output cl_grab_pkg::rec_t rec_data,
  output logic [3:0]        led
);

  logic                 arm_pulse, cont_mode, armed;
  logic                 x_wr, y_wr, z_wr;
  cl_grab_pkg::x_tap_t  x_din, x_dout;
  cl_grab_pkg::yz_tap_t y_din, y_dout;
  cl_grab_pkg::yz_tap_t z_din, z_dout;
  logic                 x_empty, y_empty, z_empty;
  logic                 x_ovf, y_ovf, z_ovf;
  logic                 ovf_any;
  logic                 pop;
  logic                 rec_full;
  cl_grab_pkg::rec_t    rec;

  assign ovf_any = x_ovf | y_ovf | z_ovf;

  frame_line_tracker tracker (
    .bus_clk, .reset, .fval, .x_lval, .y_lval, .z_lval,
    .x_valid, .x_data, .y_valid, .y_data, .z_valid, .z_data,
    .arm_pulse, .cont_mode,
    .x_wr, .x_din, .y_wr, .y_din, .z_wr, .z_din, .armed
  );

  cl_fifo #(.payload_t(cl_grab_pkg::x_tap_t), .depth(tap_depth)) x_tap_fifo (
    .bus_clk, .reset, .wr(x_wr), .din(x_din), .rd(pop),
    .dout(x_dout), .full(), .empty(x_empty), .ovf(x_ovf)
  );

  cl_fifo #(.payload_t(cl_grab_pkg::yz_tap_t), .depth(tap_depth)) y_tap_fifo (
    .bus_clk, .reset, .wr(y_wr), .din(y_din), .rd(pop),
    .dout(y_dout), .full(), .empty(y_empty), .ovf(y_ovf)
  );

  cl_fifo #(.payload_t(cl_grab_pkg::yz_tap_t), .depth(tap_depth)) z_tap_fifo (
    .bus_clk, .reset, .wr(z_wr), .din(z_din), .rd(pop),
    .dout(z_dout), .full(), .empty(z_empty), .ovf(z_ovf)
  );

  tap_reassembler reassembler (
    .bus_clk, .reset, .x_dout, .x_empty, .y_dout, .y_empty, .z_dout, .z_empty,
    .rec_full, .pop, .rec
  );

  // Host side, read first word through
  cl_fifo #(.payload_t(cl_grab_pkg::rec_t), .depth(rec_depth)) rec_fifo (
    .bus_clk, .reset, .wr(pop), .din(rec), .rd(rec_rden),
    .dout(rec_data), .full(rec_full), .empty(rec_empty), .ovf()
  );

  host_ctrl_axil regs (
    .bus_clk, .reset,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .ovf_any, .armed, .rec_push(pop),
    .arm_pulse, .cont_mode, .led
  );

endmodule

//--- frame_line_tracker.sv
`timescale 1ns/1ps

module frame_line_tracker (
  input  logic                 bus_clk,
  input  logic                 reset,
  input  logic                 fval,
  input  logic                 x_lval,
  input  logic                 y_lval,
  input  logic                 z_lval,
  input  logic                 x_valid,
  input  logic [25:0]          x_data,
  input  logic                 y_valid,
  input  logic [26:0]          y_data,
  input  logic                 z_valid,
  input  logic [26:0]          z_data,
  input  logic                 arm_pulse,
  input  logic                 cont_mode,
  output logic                 x_wr,
  output cl_grab_pkg::x_tap_t  x_din,
  output logic                 y_wr,
  output cl_grab_pkg::yz_tap_t y_din,
  output logic                 z_wr,
  output cl_grab_pkg::yz_tap_t z_din,
  output logic                 armed
);

  logic                               fval_q;
  logic                               x_lval_q;
  logic                               fval_rise;
  logic                               x_lval_rise;
  logic                               capture_active;
  logic                               arm_pending;
  logic                               cap_now;
  logic [cl_grab_pkg::frame_num_w-1:0] frame_num;
  logic [cl_grab_pkg::frame_num_w-1:0] frame_now;
  logic [cl_grab_pkg::line_num_w-1:0]  line_num;
  logic [cl_grab_pkg::line_num_w-1:0]  line_now;

  assign fval_rise   = fval & ~fval_q;
  assign x_lval_rise = x_lval & ~x_lval_q;

  // Capture decision is taken at the frame start and held for the frame
  assign cap_now   = fval_rise ? (cont_mode | arm_pending) : capture_active;
  assign frame_now = fval_rise ? frame_num + 1'b1 : frame_num;
  assign armed     = arm_pending | capture_active;

  // Line number counts x_lval rises seen in this frame
  always_comb begin
    line_now = line_num;
    if (fval_rise) line_now = '0;
    if (fval && x_lval_rise) line_now = line_now + 1'b1;
  end

  always_ff @(posedge bus_clk or posedge reset) begin
    if (reset) begin
      fval_q         <= 1'b0;
      x_lval_q       <= 1'b0;
      capture_active <= 1'b0;
      arm_pending    <= 1'b0;
      frame_num      <= '0;
      line_num       <= '0;
      x_wr           <= 1'b0;
      y_wr           <= 1'b0;
      z_wr           <= 1'b0;
    end else begin
      fval_q         <= fval;
      x_lval_q       <= x_lval;
      capture_active <= cap_now;
      frame_num      <= frame_now;
      line_num       <= line_now;
      if (arm_pulse) arm_pending <= 1'b1;
      else if (fval_rise) arm_pending <= 1'b0;  // Consumed by this frame
      x_wr <= cap_now & x_valid;
      y_wr <= cap_now & y_valid;
      z_wr <= cap_now & z_valid;
    end
  end

  // Tap words with the stamp taken in the beat's own cycle
  always_ff @(posedge bus_clk) begin
    x_din.data  <= x_data;
    x_din.fval  <= fval;
    x_din.lval  <= x_lval;
    x_din.line  <= line_now;
    x_din.frame <= frame_now;
    y_din.data  <= y_data;
    y_din.lval  <= y_lval;
    z_din.data  <= z_data;
    z_din.lval  <= z_lval;
  end

  // Captured beats only arrive inside a frame
  a_wr_gated: assert property (@(posedge bus_clk) disable iff (reset)
    (x_wr || y_wr || z_wr) |-> capture_active && $past(fval));

endmodule

//--- host_ctrl_axil.sv
`timescale 1ns/1ps

module host_ctrl_axil (
  input  logic        bus_clk,
  input  logic        reset,
  input  logic [3:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [3:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  input  logic        ovf_any,
  input  logic        armed,
  input  logic        rec_push,
  output logic        arm_pulse,
  output logic        cont_mode,
  output logic [3:0]  led
);

  logic        busy;
  logic        wr_go;
  logic        rd_go;
  logic        ovf_sticky;
  logic [31:0] led_reg;
  logic [31:0] rec_count;
  logic [31:0] rd_word;

  // Single outstanding transaction, writes win a tie
  assign busy  = awready | arready | bvalid | rvalid;
  assign wr_go = awvalid & wvalid & ~busy;
  assign rd_go = arvalid & ~busy & ~wr_go;
  assign bresp = 2'b00;
  assign rresp = 2'b00;
  assign led   = led_reg[3:0];

  always_ff @(posedge bus_clk or posedge reset) begin
    if (reset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      awready <= wr_go;
      wready  <= wr_go;
      arready <= rd_go;
      if (awready) bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
      if (arready) rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
    end
  end

  always_ff @(posedge bus_clk or posedge reset) begin
    if (reset) begin
      arm_pulse  <= 1'b0;
      cont_mode  <= 1'b0;
      ovf_sticky <= 1'b0;
      led_reg    <= '0;
      rec_count  <= '0;
    end else begin
      arm_pulse <= 1'b0;
      if (rec_push) rec_count <= rec_count + 1'b1;  // Wraps at 32 bits
      if (awready) begin
        case (awaddr)
          cl_grab_pkg::reg_ctrl: if (wstrb[0]) begin
            arm_pulse <= wdata[cl_grab_pkg::ctrl_arm_bit];
            cont_mode <= wdata[cl_grab_pkg::ctrl_cont_bit];
          end
          cl_grab_pkg::reg_status: begin
            if (wstrb[0] && wdata[cl_grab_pkg::status_ovf_bit]) ovf_sticky <= 1'b0;
          end
          cl_grab_pkg::reg_led: begin
            for (int b = 0; b < 4; b++) begin
              if (wstrb[b]) led_reg[8*b +: 8] <= wdata[8*b +: 8];
            end
          end
          default: ;
        endcase
      end
      if (ovf_any) ovf_sticky <= 1'b1;  // New overflow beats a clear
    end
  end

  always_comb begin
    rd_word = '0;
    case (araddr)
      cl_grab_pkg::reg_ctrl:  rd_word[cl_grab_pkg::ctrl_cont_bit] = cont_mode;
      cl_grab_pkg::reg_status: begin
        rd_word[cl_grab_pkg::status_ovf_bit]   = ovf_sticky;
        rd_word[cl_grab_pkg::status_armed_bit] = armed;
      end
      cl_grab_pkg::reg_led:   rd_word = led_reg;
      cl_grab_pkg::reg_count: rd_word = rec_count;
      default:                rd_word = '0;
    endcase
  end

  // Read data captured in the address accept cycle
  always_ff @(posedge bus_clk) begin
    if (arready) rdata <= rd_word;
  end

  a_no_aw_during_b: assert property (@(posedge bus_clk) disable iff (reset)
    !(bvalid && awready));

endmodule

//--- tap_reassembler.sv
`timescale 1ns/1ps

module tap_reassembler (
  input  logic                 bus_clk,
  input  logic                 reset,
  input  cl_grab_pkg::x_tap_t  x_dout,
  input  logic                 x_empty,
  input  cl_grab_pkg::yz_tap_t y_dout,
  input  logic                 y_empty,
  input  cl_grab_pkg::yz_tap_t z_dout,
  input  logic                 z_empty,
  input  logic                 rec_full,
  output logic                 pop,
  output cl_grab_pkg::rec_t    rec
);

  // One pop takes a word from every tap at once
  assign pop = ~x_empty & ~y_empty & ~z_empty & ~rec_full;

  always_comb begin
    rec.data  = {z_dout.data, y_dout.data, x_dout.data};
    rec.pad   = '0;
    rec.meta  = {z_dout.lval, y_dout.lval, x_dout.lval, x_dout.fval};
    rec.line  = x_dout.line;   // Stamp rides with the x tap
    rec.frame = x_dout.frame;
  end

  // Every popped word is a beat inside its tap's line
  a_pop_in_line: assert property (@(posedge bus_clk) disable iff (reset)
    pop |-> x_dout.lval && y_dout.lval && z_dout.lval);

endmodule

//--- tb_cl_grab.sv
`timescale 1ns/1ps

module tb_cl_grab;

  localparam int rec_depth = 8;
  localparam int line_slots = 6;  // 4 beats then 2 idle cycles per line

  logic              bus_clk;
  logic              reset;
  logic              fval, x_lval, y_lval, z_lval;
  logic              x_valid, y_valid, z_valid;
  logic [25:0]       x_data;
  logic [26:0]       y_data, z_data;
  logic [3:0]        awaddr, araddr, wstrb, led;
  logic              awvalid, awready, wvalid, wready, bvalid, bready;
  logic              arvalid, arready, rvalid, rready;
  logic [31:0]       wdata, rdata;
  logic [1:0]        bresp, rresp;
  logic              rec_rden, rec_empty;
  cl_grab_pkg::rec_t rec_data;

  logic [31:0]       lfsr_state = 32'h18f1;
  int                frame_cnt = 0;   // Counts every fval rise
  int                check_left = -1; // -1 checks every record
  bit                read_en = 1'b1;
  cl_grab_pkg::rec_t exp_q [$];

  cl_grab_top #(.tap_depth(16), .rec_depth(rec_depth)) DUT (.*);

  initial begin
    bus_clk = 1'b0;
    forever #2 bus_clk = ~bus_clk;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                             input string what);
    if (got !== exp) begin
      stop_run($sformatf("FAILED at time %0t: %s, got %h expected %h", $time, what, got, exp));
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Expected record from the frame stamp and the three tap words
  function automatic cl_grab_pkg::rec_t expected_record(input int frame, input int line,
      input logic [25:0] x, input logic [26:0] y, input logic [26:0] z);
    cl_grab_pkg::rec_t r;
    r.data  = {z, y, x};
    r.pad   = '0;
    r.meta  = 4'b1111;  // All lvals and fval high on a beat
    r.line  = line[11:0];
    r.frame = frame[19:0];
    return r;
  endfunction

  // Beat number shown by a tap in frame cycle c, or -1
  function automatic int beat_at(input int c, input int skew);
    int k;
    k = c - 1 - skew;
    if (k < 0 || k / line_slots >= 3 || k % line_slots >= 4) begin
      return -1;
    end
    return (k / line_slots) * 4 + k % line_slots;
  endfunction

  task automatic send_frame(input bit captured);
    logic [31:0] w;
    logic [25:0] xw [12];
    logic [26:0] yw [12];
    logic [26:0] zw [12];
    int          skew [3];
    int          bx, by, bz;
    for (int t = 0; t < 3; t++) begin
      take_bits(2, w);
      skew[t] = w[1:0];
    end
    for (int i = 0; i < 12; i++) begin
      take_bits(26, w);
      xw[i] = w[25:0];
      take_bits(27, w);
      yw[i] = w[26:0];
      take_bits(27, w);
      zw[i] = w[26:0];
    end
    frame_cnt++;
    if (captured) begin
      for (int i = 0; i < 12; i++) begin
        exp_q.push_back(expected_record(frame_cnt, i / 4 + 1, xw[i], yw[i], zw[i]));
      end
    end
    for (int c = 0; c < 23; c++) begin
      bx = beat_at(c, skew[0]);
      by = beat_at(c, skew[1]);
      bz = beat_at(c, skew[2]);
      @(posedge bus_clk);
      fval    <= (c < 21);  // Low for the last two cycles
      x_lval  <= (bx >= 0);
      x_valid <= (bx >= 0);
      x_data  <= (bx >= 0) ? xw[bx] : '0;
      y_lval  <= (by >= 0);
      y_valid <= (by >= 0);
      y_data  <= (by >= 0) ? yw[by] : '0;
      z_lval  <= (bz >= 0);
      z_valid <= (bz >= 0);
      z_data  <= (bz >= 0) ? zw[bz] : '0;
    end
  endtask

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
    int n;
    @(posedge bus_clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hf;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    n = 0;
    do begin
      @(posedge bus_clk);
      n++;
      if (n > 50) stop_run("AXI write timed out waiting for awready and wready");
    end while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    n = 0;
    do begin
      @(posedge bus_clk);
      n++;
      if (n > 50) stop_run("AXI write timed out waiting for bvalid");
    end while (!bvalid);
    check_value(bresp, 2'b00, "write response");
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
    int n;
    @(posedge bus_clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b1;
    n = 0;
    do begin
      @(posedge bus_clk);
      n++;
      if (n > 50) stop_run("AXI read timed out waiting for arready");
    end while (!arready);
    arvalid <= 1'b0;
    n = 0;
    do begin
      @(posedge bus_clk);
      n++;
      if (n > 50) stop_run("AXI read timed out waiting for rvalid");
    end while (!rvalid);
    data = rdata;
    check_value(rresp, 2'b00, "read response");
    rready <= 1'b0;
  endtask

  task automatic wait_records_done();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      @(posedge bus_clk);
      n++;
      if (n > 3000) stop_run("Expected records never reached the host read port");
    end
    repeat (30) @(posedge bus_clk);  // Room for a stray record to show up
  endtask

  task automatic wait_checked();
    int n;
    n = 0;
    while (check_left != 0) begin
      @(posedge bus_clk);
      n++;
      if (n > 3000) stop_run("Stored records were not read out after resuming");
    end
  endtask

  task automatic wait_drained();
    int n;
    int quiet;
    n = 0;
    quiet = 0;
    while (quiet < 40) begin
      @(posedge bus_clk);
      quiet = (rec_empty && !rec_rden) ? quiet + 1 : 0;
      n++;
      if (n > 3000) stop_run("Record FIFO never drained");
    end
  endtask

  // Reader, one pop every other cycle, compares each popped record
  initial begin
    rec_rden = 1'b0;
    forever begin
      @(posedge bus_clk);
      if (rec_rden) begin
        rec_rden <= 1'b0;
        if (check_left != 0) begin
          if (exp_q.size() == 0) begin
            stop_run("Unexpected record at the host read port");
          end else begin
            check_value(rec_data, exp_q.pop_front(), "record");
            if (check_left > 0) check_left--;
          end
        end
      end else if (read_en && !rec_empty) begin
        rec_rden <= 1'b1;
      end
    end
  end

  initial begin
    logic [31:0] rd;
    reset   = 1'b1;
    fval    = 1'b0;
    x_lval  = 1'b0;
    y_lval  = 1'b0;
    z_lval  = 1'b0;
    x_valid = 1'b0;
    y_valid = 1'b0;
    z_valid = 1'b0;
    x_data  = '0;
    y_data  = '0;
    z_data  = '0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (4) @(posedge bus_clk);
    reset <= 1'b0;
    repeat (2) @(posedge bus_clk);

    axi_write(cl_grab_pkg::reg_led, 32'h0000_00a5);
    axi_read(cl_grab_pkg::reg_led, rd);
    check_value(rd, 32'h0000_00a5, "LED register readback");
    check_value(led, 4'h5, "led pins");

    // No arm yet, nothing may come out
    send_frame(1'b0);
    send_frame(1'b0);
    wait_records_done();
    check_value(rec_empty, 1'b1, "rec_empty after unarmed frames");
    axi_read(cl_grab_pkg::reg_count, rd);
    check_value(rd, 32'd0, "record count after unarmed frames");

    axi_write(cl_grab_pkg::reg_ctrl, 32'd1 << cl_grab_pkg::ctrl_arm_bit);
    send_frame(1'b1);
    send_frame(1'b0);  // Arm is used up by the frame before
    wait_records_done();
    axi_read(cl_grab_pkg::reg_count, rd);
    check_value(rd, 32'd12, "record count after single arm");

    axi_write(cl_grab_pkg::reg_ctrl, 32'd1 << cl_grab_pkg::ctrl_cont_bit);
    repeat (3) send_frame(1'b1);
    axi_write(cl_grab_pkg::reg_ctrl, 32'd0);
    send_frame(1'b0);
    wait_records_done();
    axi_read(cl_grab_pkg::reg_count, rd);
    check_value(rd, 32'd48, "record count after continuous mode");

    // Paused reader, tap FIFOs fill and overflow
    read_en = 1'b0;
    axi_write(cl_grab_pkg::reg_ctrl, 32'd1 << cl_grab_pkg::ctrl_cont_bit);
    repeat (4) send_frame(1'b1);
    axi_write(cl_grab_pkg::reg_ctrl, 32'd0);
    axi_read(cl_grab_pkg::reg_status, rd);
    check_value(rd[cl_grab_pkg::status_ovf_bit], 1'b1, "sticky overflow bit");
    check_left = rec_depth;
    read_en = 1'b1;
    wait_checked();
    wait_drained();
    exp_q.delete();
    check_left = -1;
    axi_write(cl_grab_pkg::reg_status, 32'd1 << cl_grab_pkg::status_ovf_bit);
    axi_read(cl_grab_pkg::reg_status, rd);
    check_value(rd[cl_grab_pkg::status_ovf_bit], 1'b0, "overflow bit after clear");

    $display("Everything OK");
    $finish;
  end

endmodule
